// ==== logic/aux_window.sv ====
`default_nettype none

`include "video_macros.svh"

module aux_window (
	input  wire                          clk50m_bufg,
	input  wire                          RSTBTN,
	input  wire [`CNT_W-1:0]             hcount,
	input  wire                          hblank,
	input  wire [`CNT_W-1:0]             hssync,    // Window start
	input  wire                          aux_empty,
	output logic                         aux_pop,
	input  wire video_stream_pkg::aux_t  aux_word,
	output logic                         ade,       // Aux data enable
	output video_stream_pkg::aux_t       aux_out
);

	localparam int WIN_W = $clog2(`AUX_BURST);

	logic [WIN_W-1:0] win_left; // Cycles after the opening one
	logic open;
	logic in_window;

	assign open      = hblank && (hcount == hssync);
	assign in_window = open || (win_left != '0);
	assign aux_pop   = in_window && !aux_empty; // Skip when nothing queued

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			win_left <= '0;
			ade      <= 1'b0;
		end else begin
			if (open)
				win_left <= WIN_W'(`AUX_BURST - 1);
			else if (win_left != '0)
				win_left <= win_left - 1'b1;
			ade <= aux_pop; // Word is out of the FIFO now
		end
	end

	assign aux_out = ade ? aux_word : '0;

endmodule

`default_nettype wire

// ==== logic/credit_fifo.sv ====
`default_nettype none

`include "video_macros.svh"

module credit_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  wire           clk50m_bufg,
	input  wire           RSTBTN,
	input  wire           valid,  // Sender spends a credit
	input  wire payload_t data,
	output logic          credit, // One per pop
	input  wire           pop,
	output logic          empty,
	output payload_t      word    // Valid the cycle after pop
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	payload_t mem [`FIFO_DEPTH];
	logic [PTR_W:0] wr_ptr; // Extra bit tells full from empty
	logic [PTR_W:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty   = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign do_push = valid && !full; // Credits keep this from dropping
	assign do_pop  = pop && !empty;

	////////////////////////////////////////
	// Pointers and credit return
	////////////////////////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			credit <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			credit <= do_pop; // Same cycle as the word
		end
	end

	// Storage and read register
	always_ff @(posedge clk50m_bufg) begin
		if (do_push)
			mem[wr_ptr[PTR_W-1:0]] <= data;
		if (do_pop)
			word <= mem[rd_ptr[PTR_W-1:0]];
	end

endmodule

`default_nettype wire

// ==== logic/mode_table.sv ====
`default_nettype none

`include "video_macros.svh"

module mode_table (
	input  wire                       clk50m_bufg,
	input  wire                       RSTBTN,
	input  wire [`FMT_W-1:0]          fmt_code,
	input  wire                       fmt_load,
	output video_mode_pkg::raster_t   raster,
	output logic                      restart  // Counters back to zero
);

	// Pixels, porches and sync widths into region ends
	function automatic video_mode_pkg::raster_t make_raster(
		input logic [`CNT_W-1:0] hpix, hfp, hsw, hbp,
		input logic [`CNT_W-1:0] vlin, vfp, vsw, vbp,
		input logic              neg
	);
		video_mode_pkg::raster_t r;
		r.hsblnk  = hpix - 1'b1;
		r.hssync  = hpix - 1'b1 + hfp;
		r.hesync  = hpix - 1'b1 + hfp + hsw;
		r.heblnk  = hpix - 1'b1 + hfp + hsw + hbp;
		r.vsblnk  = vlin - 1'b1;
		r.vssync  = vlin - 1'b1 + vfp;
		r.vesync  = vlin - 1'b1 + vfp + vsw;
		r.veblnk  = vlin - 1'b1 + vfp + vsw + vbp;
		r.neg_pol = neg;
		return r;
	endfunction

	// pixels fp sync bp, lines fp sync bp, polarity
	localparam video_mode_pkg::raster_t VGA_T = make_raster(11'd640, 11'd16, 11'd96, 11'd48,
		11'd480, 11'd11, 11'd2, 11'd31, 1'b1);
	localparam video_mode_pkg::raster_t SVGA_T = make_raster(11'd800, 11'd40, 11'd128, 11'd88,
		11'd600, 11'd1, 11'd4, 11'd23, 1'b0);
	localparam video_mode_pkg::raster_t XGA_T = make_raster(11'd1024, 11'd24, 11'd136, 11'd160,
		11'd768, 11'd3, 11'd6, 11'd29, 1'b1);
	localparam video_mode_pkg::raster_t SXGA_T = make_raster(11'd1280, 11'd48, 11'd112, 11'd248,
		11'd1024, 11'd1, 11'd3, 11'd38, 1'b0);
	localparam video_mode_pkg::raster_t HD720_T = make_raster(11'd1280, 11'd110, 11'd40, 11'd220,
		11'd720, 11'd5, 11'd5, 11'd20, 1'b0);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			raster  <= HD720_T; // 720p until first load
			restart <= 1'b1;    // Leaves one pulse after reset
		end else begin
			restart <= fmt_load;
			if (fmt_load) begin
				case (fmt_code)
					video_mode_pkg::FMT_VGA:  raster <= VGA_T;
					video_mode_pkg::FMT_SVGA: raster <= SVGA_T;
					video_mode_pkg::FMT_XGA:  raster <= XGA_T;
					video_mode_pkg::FMT_SXGA: raster <= SXGA_T;
					default:                  raster <= HD720_T; // Unknown codes too
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/raster_timing.sv ====
`default_nettype none

`include "video_macros.svh"

module raster_timing (
	input  wire                            clk50m_bufg,
	input  wire                            RSTBTN,
	input  wire video_mode_pkg::raster_t   raster,
	input  wire                            restart,
	output logic                           pix_pop,   // Pixel FIFO read
	input  wire                            pix_empty,
	input  wire video_stream_pkg::pixel_t  pix_word,  // FIFO output register
	output logic [`CNT_W-1:0]              hcount,
	output logic                           hblank,
	output logic                           hsync,
	output logic                           vsync,
	output logic                           de,
	output logic [`COLOR_W-1:0]            red,
	output logic [`COLOR_W-1:0]            green,
	output logic [`COLOR_W-1:0]            blue,
	output logic                           underflow  // Sticky
);

	logic [`CNT_W-1:0] vcount;
	logic line_end, frame_end;
	logic vblank, hsync_c, vsync_c, active;
	logic hsync_q, vsync_q, active_q; // Middle stage
	logic popped;                     // Word on pix_word belongs to this de

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	assign line_end  = (hcount == raster.heblnk);
	assign frame_end = (vcount == raster.veblnk);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			vcount <= frame_end ? '0 : vcount + 1'b1; // Next line or new frame
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	////////////////////////////////////////
	// Region decode
	////////////////////////////////////////

	assign hblank  = (hcount > raster.hsblnk);
	assign vblank  = (vcount > raster.vsblnk);
	assign hsync_c = (hcount > raster.hssync) && (hcount <= raster.hesync);
	assign vsync_c = (vcount > raster.vssync) && (vcount <= raster.vesync);
	assign active  = !hblank && !vblank;

	// Pop one stage early, word lands with de
	assign pix_pop = active_q && !pix_empty;

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			hsync_q   <= 1'b0; // Inactive level of 720p
			vsync_q   <= 1'b0;
			active_q  <= 1'b0;
			hsync     <= 1'b0;
			vsync     <= 1'b0;
			de        <= 1'b0;
			popped    <= 1'b0;
			underflow <= 1'b0;
		end else begin
			hsync_q  <= hsync_c ^ raster.neg_pol;
			vsync_q  <= vsync_c ^ raster.neg_pol;
			active_q <= active;
			hsync    <= hsync_q;
			vsync    <= vsync_q;
			de       <= active_q;
			popped   <= pix_pop;
			if (active_q && pix_empty)
				underflow <= 1'b1; // Raster never waits
		end
	end

	// Black on blank and on a missed pixel
	assign red   = popped ? pix_word.red   : '0;
	assign green = popped ? pix_word.green : '0;
	assign blue  = popped ? pix_word.blue  : '0;

endmodule

`default_nettype wire

// ==== logic/switch_conditioner.sv ====
`default_nettype none

`include "video_macros.svh"

module switch_conditioner (
	input  wire                       clk50m_bufg,
	input  wire                       RSTBTN,
	input  wire [`FMT_W-1:0]          sw,       // Raw DIP switches
	output video_mode_pkg::fmt_code_t fmt_code, // Settled format
	output logic                      fmt_load  // One pulse per settled change
);

	localparam int DB_W = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [`FMT_W-1:0] sw_meta; // First sync stage
	logic [`FMT_W-1:0] sw_sync; // Second sync stage
	logic [`FMT_W-1:0] sw_held; // Compare stage
	logic [DB_W-1:0]   db_cnt;  // Cycles the code has held
	logic              stable;
	logic              settle;

	assign stable = (sw_sync == sw_held);
	// Last held cycle before the load
	assign settle = stable && (db_cnt == DB_W'(`DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta  <= '0;
			sw_sync  <= '0;
			sw_held  <= '0;
			db_cnt   <= '0;
			fmt_load <= 1'b0;
			fmt_code <= video_mode_pkg::FMT_DEFAULT;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_held <= sw_sync;

			// Any change restarts the debounce
			if (!stable)
				db_cnt <= '0;
			else if (db_cnt != DB_W'(`DEBOUNCE_CYCLES))
				db_cnt <= db_cnt + 1'b1; // Saturates, so only one load

			fmt_load <= settle;
			if (settle)
				fmt_code <= video_mode_pkg::fmt_code_t'(sw_held);
		end
	end

endmodule

`default_nettype wire

// ==== logic/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////

// Raster counters and every timing boundary
`define CNT_W 11

// One color channel
`define COLOR_W 8

// One auxiliary nibble, three per aux word
`define AUX_NIB_W 4

// Format switch bank
`define FMT_W 4

////////////////////////////////////////
// Timing and sizing
////////////////////////////////////////

`define DEBOUNCE_CYCLES 1024 // Cycles a code must hold before load
`define AUX_BURST 32         // Aux window length in cycles

// Entries per FIFO, also the sender's starting credit
`define FIFO_DEPTH 16

`endif

// ==== logic/video_mode_pkg.sv ====
`default_nettype none

`include "video_macros.svh"

package video_mode_pkg;

	////////////////////////////////////////
	// Raster format codes
	////////////////////////////////////////

	// Same codes as the board's DIP switches
	typedef enum logic [`FMT_W-1:0] {
		FMT_VGA      = 4'b0000, // 640x480
		FMT_SVGA     = 4'b0001, // 800x600
		FMT_HDTV720P = 4'b0010, // 1280x720
		FMT_XGA      = 4'b0011, // 1024x768
		FMT_SXGA     = 4'b1000  // 1280x1024
	} fmt_code_t;

	// Power-up format and fallback for unknown codes
	localparam fmt_code_t FMT_DEFAULT = FMT_HDTV720P;

	////////////////////////////////////////
	// Timing boundaries of one format
	////////////////////////////////////////

	// Boundaries as last count of each region
	typedef struct packed {
		logic [`CNT_W-1:0] hsblnk; // Last active pixel
		logic [`CNT_W-1:0] hssync; // Last front porch pixel
		logic [`CNT_W-1:0] hesync; // Last sync pixel
		logic [`CNT_W-1:0] heblnk; // Last pixel of line
		logic [`CNT_W-1:0] vsblnk; // Last active line
		logic [`CNT_W-1:0] vssync; // Last front porch line
		logic [`CNT_W-1:0] vesync; // Last sync line
		logic [`CNT_W-1:0] veblnk; // Last line of frame
		logic              neg_pol; // Sync asserted low
	} raster_t;

endpackage

`default_nettype wire

// ==== logic/video_out_top.sv ====
`default_nettype none

`include "video_macros.svh"

module video_out_top (
	input  wire                            clk50m_bufg,
	input  wire                            RSTBTN,
	input  wire [`FMT_W-1:0]               sw,
	// Pixel stream in
	input  wire                            pix_valid,
	input  wire video_stream_pkg::pixel_t  pix_data,
	output wire                            pix_credit,
	// Aux stream in
	input  wire                            aux_valid,
	input  wire video_stream_pkg::aux_t    aux_data,
	output wire                            aux_credit,
	// Video out
	output wire                            hsync,
	output wire                            vsync,
	output wire                            de,
	output wire [`COLOR_W-1:0]             red,
	output wire [`COLOR_W-1:0]             green,
	output wire [`COLOR_W-1:0]             blue,
	output wire                            ade,
	output wire video_stream_pkg::aux_t    aux_out,
	output wire                            underflow
);

	video_mode_pkg::fmt_code_t fmt_code;
	video_mode_pkg::raster_t   raster;
	video_stream_pkg::pixel_t  pix_word;
	video_stream_pkg::aux_t    aux_word;
	wire fmt_load, restart;
	wire pix_pop, pix_empty, aux_pop, aux_empty;
	wire hblank;
	wire [`CNT_W-1:0] hcount;

	////////////////////////////////////////
	// Format control
	////////////////////////////////////////

	switch_conditioner u_sw (.clk50m_bufg, .RSTBTN, .sw, .fmt_code, .fmt_load);

	mode_table u_mode (.clk50m_bufg, .RSTBTN, .fmt_code, .fmt_load, .raster, .restart);

	////////////////////////////////////////
	// Pixel path
	////////////////////////////////////////

	credit_fifo #(.payload_t(video_stream_pkg::pixel_t)) u_pix_fifo (
		.clk50m_bufg, .RSTBTN, .valid(pix_valid), .data(pix_data), .credit(pix_credit),
		.pop(pix_pop), .empty(pix_empty), .word(pix_word)
	);

	raster_timing u_raster (
		.clk50m_bufg, .RSTBTN, .raster, .restart, .pix_pop, .pix_empty, .pix_word,
		.hcount, .hblank, .hsync, .vsync, .de, .red, .green, .blue, .underflow
	);

	// Aux path, read in horizontal blanking
	credit_fifo #(.payload_t(video_stream_pkg::aux_t)) u_aux_fifo (
		.clk50m_bufg, .RSTBTN, .valid(aux_valid), .data(aux_data), .credit(aux_credit),
		.pop(aux_pop), .empty(aux_empty), .word(aux_word)
	);

	aux_window u_aux (
		.clk50m_bufg, .RSTBTN, .hcount, .hblank, .hssync(raster.hssync),
		.aux_empty, .aux_pop, .aux_word, .ade, .aux_out
	);

endmodule

`default_nettype wire

// ==== logic/video_stream_pkg.sv ====
`default_nettype none

`include "video_macros.svh"

package video_stream_pkg;

	// One pixel, red in the top byte
	typedef struct packed {
		logic [`COLOR_W-1:0] red;
		logic [`COLOR_W-1:0] green;
		logic [`COLOR_W-1:0] blue;
	} pixel_t;

	// Auxiliary word sent during horizontal blanking
	// Nibble order matches the encoder's aux2/aux1/aux0 lanes
	typedef struct packed {
		logic [`AUX_NIB_W-1:0] aux2;
		logic [`AUX_NIB_W-1:0] aux1;
		logic [`AUX_NIB_W-1:0] aux0; // Lowest lane
	} aux_t;

endpackage

`default_nettype wire

// ==== verif/video_out_asserts.sv ====
`default_nettype none

`include "video_macros.svh"

module video_out_asserts (
	input wire clk50m_bufg,
	input wire RSTBTN,
	input wire pix_valid,
	input wire pix_credit,
	input wire aux_valid,
	input wire aux_credit,
	input wire hsync,
	input wire vsync,
	input wire de,
	input wire ade,
	input wire neg_pol  // Current format's sync polarity
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int OCC_W = $clog2(`FIFO_DEPTH) + 1;

	logic [OCC_W-1:0] pix_held; // Credits spent and not yet returned
	logic [OCC_W-1:0] aux_held;
	int fail_count = 0;         // Failed properties so far

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			pix_held <= '0;
			aux_held <= '0;
		end else begin
			pix_held <= pix_held + OCC_W'(pix_valid) - OCC_W'(pix_credit);
			aux_held <= aux_held + OCC_W'(aux_valid) - OCC_W'(aux_credit);
		end
	end

	// All credits out means the FIFO may be full
	a_pix_room: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		pix_valid |-> (pix_held < OCC_W'(`FIFO_DEPTH)))
		else begin
			$error("pixel valid without a credit");
			fail_count++;
		end

	a_aux_room: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		aux_valid |-> (aux_held < OCC_W'(`FIFO_DEPTH)))
		else begin
			$error("aux valid without a credit");
			fail_count++;
		end

	// Outputs lag the polarity by two stages
	a_de_rise: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		$rose(de) |-> (hsync == $past(neg_pol, 2)) && (vsync == $past(neg_pol, 2)))
		else begin
			$error("de rose during sync");
			fail_count++;
		end

	a_ade_blank: assert property (@(posedge clk50m_bufg) disable iff (RSTBTN)
		ade |-> !de)
		else begin
			$error("ade during active video");
			fail_count++;
		end

endmodule

bind video_out_top video_out_asserts u_asserts (
	.clk50m_bufg, .RSTBTN, .pix_valid, .pix_credit, .aux_valid, .aux_credit,
	.hsync, .vsync, .de, .ade, .neg_pol(raster.neg_pol)
);

`default_nettype wire

// ==== verif/video_out_tb.sv ====
`default_nettype none

`include "video_macros.svh"

module video_out_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int VGA_FRAME = 800 * 524;   // Longest frame any test measures
	localparam int HD_FRAME  = 1650 * 750;  // Margin for a stream waiting out vblank
	localparam int LINE_MAX  = 1688;        // SXGA line
	localparam int SETTLE    = `DEBOUNCE_CYCLES + 10; // Debounce, load, restart, output delay
	localparam int WATCHDOG  = 2 * VGA_FRAME + HD_FRAME + 8 * SETTLE + 40 * LINE_MAX;
	localparam int N_PIX     = 2000; // About a line and a half of 720p
	localparam int N_AUX     = 80;

	logic clk50m_bufg = 1'b0;
	logic RSTBTN = 1'b1;
	logic [`FMT_W-1:0] sw = 4'b0010;
	logic pix_valid = 1'b0;
	video_stream_pkg::pixel_t pix_data = '0;
	logic aux_valid = 1'b0;
	video_stream_pkg::aux_t aux_data = '0;

	wire pix_credit;
	wire aux_credit;
	wire hsync;
	wire vsync;
	wire de;
	wire ade;
	wire underflow;
	wire [`COLOR_W-1:0] red;
	wire [`COLOR_W-1:0] green;
	wire [`COLOR_W-1:0] blue;
	wire video_stream_pkg::aux_t aux_out;

	video_stream_pkg::pixel_t pix_todo[$]; // Waiting for a credit
	video_stream_pkg::pixel_t pix_exp[$];  // Sent but not yet on the outputs
	video_stream_pkg::aux_t   aux_todo[$];
	video_stream_pkg::aux_t   aux_exp[$];
	int pix_credits = 0;
	int aux_credits = 0;
	int aux_line_cnt = 0;  // ade cycles since the last sync end
	int error_count = 0;
	logic pix_check = 1'b0;
	logic aux_check = 1'b0;
	logic hsync_prev = 1'b0;

	video_out_top dut (
		.clk50m_bufg, .RSTBTN, .sw, .pix_valid, .pix_data, .pix_credit,
		.aux_valid, .aux_data, .aux_credit, .hsync, .vsync, .de,
		.red, .green, .blue, .ade, .aux_out, .underflow
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	////////////////////////////////////////
	// Reporting
	////////////////////////////////////////

	task automatic stop_run;
		error_count++;
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic fail_run(input string why);
		$display("ERROR: %s at %0t", why, $time);
		stop_run();
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			stop_run();
		end
	endtask

	initial begin
		repeat (WATCHDOG) @(posedge clk50m_bufg);
		fail_run("watchdog expired, a test stopped making progress");
	end

	// Bound checker keeps a count of failed properties
	always @(negedge clk50m_bufg) begin
		if (dut.u_asserts.fail_count != 0)
			fail_run("a bound assertion on the top level failed");
	end

	////////////////////////////////////////
	// Credit senders
	////////////////////////////////////////

	// One word per held credit with a credit back on each pulse
	always @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			pix_credits <= `FIFO_DEPTH;
			pix_valid   <= 1'b0;
		end else if (pix_todo.size() != 0 && pix_credits != 0) begin
			pix_valid   <= 1'b1;
			pix_data    <= pix_todo[0];
			pix_exp.push_back(pix_todo.pop_front());
			pix_credits <= pix_credits - 1 + pix_credit;
		end else begin
			pix_valid   <= 1'b0;
			pix_credits <= pix_credits + pix_credit;
		end
	end

	always @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			aux_credits <= `FIFO_DEPTH;
			aux_valid   <= 1'b0;
		end else if (aux_todo.size() != 0 && aux_credits != 0) begin
			aux_valid   <= 1'b1;
			aux_data    <= aux_todo[0];
			aux_exp.push_back(aux_todo.pop_front());
			aux_credits <= aux_credits - 1 + aux_credit;
		end else begin
			aux_valid   <= 1'b0;
			aux_credits <= aux_credits + aux_credit;
		end
	end

	////////////////////////////////////////
	// Output monitors
	////////////////////////////////////////

	always @(negedge clk50m_bufg) begin
		if (pix_check && de && pix_exp.size() != 0)
			check_eq("rgb", {red, green, blue}, pix_exp.pop_front()); // In send order
		if (aux_check && ade) begin
			if (aux_exp.size() == 0) begin
				fail_run("ade high with no aux word outstanding");
			end else begin
				check_eq("aux_out", aux_out, aux_exp.pop_front());
				check_eq("de_at_ade", de, 1'b0);
				aux_line_cnt++;
			end
		end
		if (aux_line_cnt > `AUX_BURST)
			fail_run("more aux words in one line than the window allows");
		if (hsync_prev && !hsync)
			aux_line_cnt = 0; // 720p sync ends after the window closes
		hsync_prev = hsync;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic apply_reset;
		RSTBTN <= 1'b1;
		repeat (3) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
	endtask

	// New code then wait out debounce and restart
	task automatic set_format(input logic [`FMT_W-1:0] code);
		@(posedge clk50m_bufg);
		sw <= code;
		repeat (SETTLE) @(posedge clk50m_bufg);
	endtask

	task automatic wait_de_fall;
		logic prev;
		@(negedge clk50m_bufg);
		prev = de;
		@(negedge clk50m_bufg);
		while (!(prev && !de)) begin
			prev = de;
			@(negedge clk50m_bufg);
		end
	endtask

	// Reference raster per format with unknown codes as 720p
	task automatic expect_format(input logic [`FMT_W-1:0] code, output int total,
		output int sync_w, output int act_w, output int lines, output logic act);
		case (code)
			4'b0000: begin
				total = 800;
				sync_w = 96;
				act_w = 640;
				lines = 524;
				act = 1'b0; // VGA syncs low
			end
			4'b0001: begin
				total = 1056;
				sync_w = 128;
				act_w = 800;
				lines = 628;
				act = 1'b1;
			end
			4'b0011: begin
				total = 1344;
				sync_w = 136;
				act_w = 1024;
				lines = 806;
				act = 1'b0;
			end
			4'b1000: begin
				total = 1688;
				sync_w = 112;
				act_w = 1280;
				lines = 1066;
				act = 1'b1;
			end
			default: begin
				total = 1650;
				sync_w = 40;
				act_w = 1280;
				lines = 750;
				act = 1'b1;
			end
		endcase
	endtask

	// Edge to edge of the asserted hsync level
	task automatic measure_line(input logic act, output int period, output int width,
		output int de_cycles);
		logic prev;
		period = 0;
		width = 0;
		de_cycles = 0;
		@(negedge clk50m_bufg);
		prev = hsync;
		@(negedge clk50m_bufg);
		while (!(hsync === act && prev !== act)) begin
			prev = hsync;
			@(negedge clk50m_bufg);
		end
		do begin
			if (hsync === act)
				width++;
			if (de === 1'b1)
				de_cycles++; // Belongs to the following line
			prev = hsync;
			@(negedge clk50m_bufg);
			period++;
		end while (!(hsync === act && prev !== act));
	endtask

	task automatic measure_frame(input logic act, output int period);
		logic prev;
		period = 0;
		@(negedge clk50m_bufg);
		prev = vsync;
		@(negedge clk50m_bufg);
		while (!(vsync === act && prev !== act)) begin
			prev = vsync;
			@(negedge clk50m_bufg);
		end
		do begin
			prev = vsync;
			@(negedge clk50m_bufg);
			period++;
		end while (!(vsync === act && prev !== act));
	endtask

	task automatic check_format(input logic [`FMT_W-1:0] code, input bit with_frame);
		int total;
		int sync_w;
		int act_w;
		int lines;
		int period;
		int width;
		int de_cycles;
		logic act;
		expect_format(code, total, sync_w, act_w, lines, act);
		measure_line(act, period, width, de_cycles);
		check_eq("line_cycles", period, total);
		check_eq("hsync_width", width, sync_w);
		check_eq("de_cycles", de_cycles, act_w);
		if (with_frame) begin
			measure_frame(act, period);
			check_eq("frame_cycles", period, lines * total);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic check_reset_state;
		@(negedge clk50m_bufg);
		check_eq("de", de, 1'b0);
		check_eq("ade", ade, 1'b0);
		check_eq("hsync", hsync, 1'b0); // 720p idles low
		check_eq("vsync", vsync, 1'b0);
		check_eq("underflow", underflow, 1'b0);
		check_eq("pix_credit", pix_credit, 1'b0);
		check_eq("aux_credit", aux_credit, 1'b0);
	endtask

	// Nothing sent so the first line starves
	task automatic test_underflow;
		@(negedge clk50m_bufg);
		while (!de)
			@(negedge clk50m_bufg);
		while (de) begin
			check_eq("rgb_starved", {red, green, blue}, 32'h0);
			@(negedge clk50m_bufg);
		end
		check_eq("underflow", underflow, 1'b1);
		repeat (3) begin
			wait_de_fall();
			check_eq("underflow_sticky", underflow, 1'b1);
		end
	endtask

	task automatic test_default_720p;
		repeat (SETTLE) @(posedge clk50m_bufg); // Load that follows every reset
		check_format(4'b0010, 1'b0);
	endtask

	task automatic test_formats;
		set_format(4'b0000);
		check_format(4'b0000, 1'b1); // VGA also gets a frame check
		set_format(4'b0001);
		check_format(4'b0001, 1'b0);
		set_format(4'b0011);
		check_format(4'b0011, 1'b0);
		set_format(4'b1000);
		check_format(4'b1000, 1'b0);
		set_format(4'b0110);
		check_format(4'b0110, 1'b0); // Unused code
	endtask

	task automatic test_pixel_stream;
		video_stream_pkg::pixel_t w;
		int i;
		wait_de_fall(); // FIFO fills in blanking before the next line
		pix_check = 1'b1;
		for (i = 0; i < N_PIX; i++) begin
			w = 24'($urandom);
			pix_todo.push_back(w);
		end
		while (pix_todo.size() != 0 || pix_exp.size() != 0)
			@(negedge clk50m_bufg);
		repeat (4) @(negedge clk50m_bufg);
		check_eq("pix_credits", pix_credits, `FIFO_DEPTH);
		pix_check = 1'b0;
	endtask

	task automatic test_aux_stream;
		video_stream_pkg::aux_t a;
		int i;
		aux_line_cnt = 0;
		aux_check = 1'b1;
		for (i = 0; i < N_AUX; i++) begin
			a = 12'($urandom);
			aux_todo.push_back(a);
		end
		while (aux_todo.size() != 0 || aux_exp.size() != 0)
			@(negedge clk50m_bufg);
		repeat (4) @(negedge clk50m_bufg);
		check_eq("aux_credits", aux_credits, `FIFO_DEPTH);
		aux_check = 1'b0;
	endtask

	initial begin
		void'($urandom(21711));
		apply_reset();
		check_reset_state();
		test_underflow();
		test_default_720p();
		test_formats();
		set_format(4'b0010);
		apply_reset();
		repeat (SETTLE) @(posedge clk50m_bufg);
		test_pixel_stream();
		test_aux_stream();
		if (error_count == 0 && dut.u_asserts.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_run("errors or failed assertions at end of run");
		end
	end

endmodule

`default_nettype wire

// ==== video_out.f ====
+incdir+logic
logic/video_mode_pkg.sv
logic/video_stream_pkg.sv
logic/switch_conditioner.sv
logic/mode_table.sv
logic/raster_timing.sv
logic/credit_fifo.sv
logic/aux_window.sv
logic/video_out_top.sv
verif/video_out_asserts.sv
verif/video_out_tb.sv
